// File: source/mbu_bus_pkg.sv
//////////////////////////////////////////////////////////////////////
// Memory bank unit, bus package
// Widths of the data and address buses the bank unit sits on, and the
// decode constants for the control unit addresses and the I/O window
//////////////////////////////////////////////////////////////////////

`default_nettype none

package mbu_bus_pkg;

   // One byte on IBUS, DB, AB or AEXT
   typedef logic [7:0] byte_t;

   // Bank register number
   typedef logic [2:0] reg_index_t;

   // Control unit read or write address
   typedef logic [4:0] micro_addr_t;

   // Size of the bank register file
   localparam int NUM_BANK_REGS = 8;

   //////////////////////////////////////////////////////////////////////
   // Control unit addresses
   //////////////////////////////////////////////////////////////////////

   // Bank register read and write over the IBUS
   localparam micro_addr_t ADDR_MBP = 5'b01100;

   // Top bits of the AR write range 00100 to 00111
   localparam logic [2:0] ADDR_AR_MBX_PREFIX = 3'b001;

   //////////////////////////////////////////////////////////////////////
   // I/O space
   //////////////////////////////////////////////////////////////////////

   // Window base, covers 0x08 to 0x0F with the system device selected
   localparam byte_t IO_MBR_BASE = 8'h08;

endpackage

`default_nettype wire

// File: source/mbu_ctl_pkg.sv
//////////////////////////////////////////////////////////////////////
// Memory bank unit, control package
// Decoded strobes and the control word that drives the register file
// and the bus drivers
//////////////////////////////////////////////////////////////////////

`default_nettype none

package mbu_ctl_pkg;

   // Decoded requests from the control unit and the I/O bus
   typedef struct packed {
      logic read_mbp;
      logic write_mbp;
      logic write_ar_mbx;
      logic io_in;
      logic io_out;
   } mbu_strobes_t;

   // Where the register index comes from
   typedef enum logic [1:0] {
      SRC_ZERO,
      SRC_IR,
      SRC_WADDR,
      SRC_AB
   } index_src_t;

   // Control word, one per decoded cycle
   typedef struct packed {
      index_src_t index_src;
      logic       reg_write;
      // Write data from DB, else from IBUS
      logic       wdata_from_db;
      logic       drive_ibus;
      logic       drive_db;
      logic       drive_aext;
   } mbu_ctl_t;

   // Quiet bus, register file output still on AEXT
   localparam mbu_ctl_t CTL_IDLE = '{SRC_ZERO, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

endpackage

`default_nettype wire

// File: source/mbu_decode.sv
//////////////////////////////////////////////////////////////////////
// Memory bank unit, address decoder
// Compares the control unit read and write addresses and the I/O
// address against the bank unit codes and forms the five strobes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mbu_decode (
   input  mbu_bus_pkg::micro_addr_t  raddr,
   input  mbu_bus_pkg::micro_addr_t  waddr,
   input  mbu_bus_pkg::byte_t        ab,
   input  logic                      sysdev,
   input  logic                      io_read,
   input  logic                      io_write,
   output mbu_ctl_pkg::mbu_strobes_t strobes
);

   import mbu_bus_pkg::*;

   // AB falls inside the register window
   logic io_window;

   // System device address in 0x08 to 0x0F
   // Low three AB bits pick the register, so only the top five are compared
   assign io_window = sysdev && (ab[7:3] == IO_MBR_BASE[7:3]);

   //////////////////////////////////////////////////////////////////////
   // Strobes
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      strobes = '0;

      // Control unit read of the bank register
      strobes.read_mbp = (raddr == ADDR_MBP);

      // Control unit write of the bank register
      strobes.write_mbp = (waddr == ADDR_MBP);

      // Any of the four AR write codes
      strobes.write_ar_mbx = (waddr[4:2] == ADDR_AR_MBX_PREFIX);

      // IN and OUT instructions addressing the window
      strobes.io_in = io_window && io_read;
      strobes.io_out = io_window && io_write;
   end

endmodule

`default_nettype wire

// File: source/mbu_control.sv
//////////////////////////////////////////////////////////////////////
// Memory bank unit, control logic
// Builds the control word from the strobes by priority, selects the
// register index and holds the unit enable flag
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mbu_control (
   input  logic                      clk,
   input  logic                      reset,
   input  mbu_ctl_pkg::mbu_strobes_t strobes,
   input  logic                      idxen,
   input  mbu_bus_pkg::reg_index_t   ir,
   input  mbu_bus_pkg::micro_addr_t  waddr,
   input  mbu_bus_pkg::byte_t        ab,
   output mbu_ctl_pkg::mbu_ctl_t     ctl,
   output mbu_bus_pkg::reg_index_t   index,
   output logic                      enabled
);

   import mbu_ctl_pkg::*;

   //////////////////////////////////////////////////////////////////////
   // Control word
   //////////////////////////////////////////////////////////////////////

   // Priority: OUT, IN, AR write, IBUS write, IBUS read
   always_comb begin
      ctl = CTL_IDLE;

      if (strobes.io_out) begin
         // OUT writes the register addressed by AB with DB data
         ctl.index_src = SRC_AB;
         ctl.reg_write = 1'b1;
         ctl.wdata_from_db = 1'b1;
      end else if (strobes.io_in) begin
         // IN puts the register addressed by AB on DB
         ctl.index_src = SRC_AB;
         ctl.drive_db = 1'b1;
      end else if (strobes.write_ar_mbx) begin
         // AR write, AEXT carries the register picked by waddr
         ctl.index_src = SRC_WADDR;
      end else if (strobes.write_mbp) begin
         ctl.index_src = idxen ? SRC_IR : SRC_ZERO;
         ctl.reg_write = 1'b1;
      end else if (strobes.read_mbp) begin
         ctl.index_src = idxen ? SRC_IR : SRC_ZERO;
      end

      // IBUS read rides along with any winner except IN
      // Keeps the IBUS and DB drivers apart
      ctl.drive_ibus = strobes.read_mbp && !ctl.drive_db;
   end

   //////////////////////////////////////////////////////////////////////
   // Index multiplexer
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      unique case (ctl.index_src)
         SRC_ZERO:  index = '0;
         SRC_IR:    index = ir;
         // Only four AR write codes, upper index bit stays clear
         SRC_WADDR: index = {1'b0, waddr[1:0]};
         SRC_AB:    index = ab[2:0];
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Enable flag
   //////////////////////////////////////////////////////////////////////

   // Cleared by reset, set by the first OUT to the window
   // Stays set until the next reset
   always_ff @(posedge clk) begin
      if (reset) begin
         enabled <= 1'b0;
      end else if (strobes.io_out) begin
         enabled <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: source/mbu_regfile.sv
//////////////////////////////////////////////////////////////////////
// Memory bank unit, register file
// Eight bank registers, one write port and one combinational read port
// Until the unit is enabled reads return the ROM/RAM default
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mbu_regfile (
   input  logic                    clk,
   input  mbu_bus_pkg::reg_index_t index,
   input  logic                    reg_write,
   input  mbu_bus_pkg::byte_t      wdata,
   input  logic                    enabled,
   input  logic                    rom_sel,
   output mbu_bus_pkg::byte_t      rdata
);

   import mbu_bus_pkg::*;

   // Bank registers, contents undefined after power up
   byte_t regs [NUM_BANK_REGS];

   // Write port
   always_ff @(posedge clk) begin
      if (reg_write) begin
         regs[index] <= wdata;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Read port
   //////////////////////////////////////////////////////////////////////

   // Disabled unit reads 0x80 or 0x00 from every register
   // so the machine boots from ROM when the switch says so
   always_comb begin
      if (enabled) begin
         rdata = regs[index];
      end else begin
         rdata = {rom_sel, 7'b0};
      end
   end

endmodule

`default_nettype wire

// File: source/mbu.sv
//////////////////////////////////////////////////////////////////////
// Memory bank unit, top level
// Eight bank registers reached from the control unit over IBUS, from
// IN and OUT through I/O 0x08 to 0x0F, and driven onto AEXT for
// AR writes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mbu (
   input  logic                     clk,
   input  logic                     reset,
   input  mbu_bus_pkg::micro_addr_t raddr,
   input  mbu_bus_pkg::micro_addr_t waddr,
   input  logic                     idxen,
   input  mbu_bus_pkg::reg_index_t  ir,
   input  mbu_bus_pkg::byte_t       ibus_in,
   input  mbu_bus_pkg::byte_t       ab,
   input  mbu_bus_pkg::byte_t       db_in,
   input  logic                     sysdev,
   input  logic                     io_read,
   input  logic                     io_write,
   input  logic                     rom_sel,
   output mbu_bus_pkg::byte_t       ibus_out,
   output logic                     ibus_drive,
   output mbu_bus_pkg::byte_t       db_out,
   output logic                     db_drive,
   output mbu_bus_pkg::byte_t       aext,
   output logic                     write_ar_mbx
);

   import mbu_bus_pkg::*;
   import mbu_ctl_pkg::*;

   mbu_strobes_t strobes;
   mbu_ctl_t     ctl;
   reg_index_t   index;
   logic         enabled;
   byte_t        wdata;
   byte_t        rdata;

   //////////////////////////////////////////////////////////////////////
   // Decode and control
   //////////////////////////////////////////////////////////////////////

   mbu_decode u_decode (
      .raddr    (raddr),
      .waddr    (waddr),
      .ab       (ab),
      .sysdev   (sysdev),
      .io_read  (io_read),
      .io_write (io_write),
      .strobes  (strobes)
   );

   mbu_control u_control (
      .clk     (clk),
      .reset   (reset),
      .strobes (strobes),
      .idxen   (idxen),
      .ir      (ir),
      .waddr   (waddr),
      .ab      (ab),
      .ctl     (ctl),
      .index   (index),
      .enabled (enabled)
   );

   // OUT takes data from DB, control unit writes from IBUS
   assign wdata = ctl.wdata_from_db ? db_in : ibus_in;

   mbu_regfile u_regfile (
      .clk       (clk),
      .index     (index),
      .reg_write (ctl.reg_write),
      .wdata     (wdata),
      .enabled   (enabled),
      .rom_sel   (rom_sel),
      .rdata     (rdata)
   );

   //////////////////////////////////////////////////////////////////////
   // Bus outputs
   //////////////////////////////////////////////////////////////////////

   // Both transceivers see the register file output
   assign ibus_out = rdata;
   assign db_out = rdata;
   assign ibus_drive = ctl.drive_ibus;
   assign db_drive = ctl.drive_db;

   // AEXT reads low when nothing drives it
   assign aext = ctl.drive_aext ? rdata : '0;

   // Convenience strobe for the AR
   assign write_ar_mbx = strobes.write_ar_mbx;

endmodule

`default_nettype wire

// File: sim/mbu_props.sv
//////////////////////////////////////////////////////////////////////
// Memory bank unit, bound checks
// Bus driver exclusivity and the rules of the enable flag
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mbu_props (
   input logic clk,
   input logic reset,
   input logic ibus_drive,
   input logic db_drive,
   input logic enabled,
   input logic io_out
);

   // IBUS and DB transceivers never on together
   drive_excl: assert property (@(posedge clk) disable iff (reset) !(ibus_drive && db_drive))
      else $error("ibus_drive and db_drive high together");

   // Flag drops only through reset
   enable_hold: assert property (@(posedge clk) enabled |=> (enabled || $past(reset)))
      else $error("enabled fell without reset");

   // Flag rises only on an OUT to the window
   enable_rise: assert property (@(posedge clk) !enabled |=> (!enabled || $past(io_out)))
      else $error("enabled rose without io_out");

endmodule

bind mbu mbu_props u_props (
   .clk        (clk),
   .reset      (reset),
   .ibus_drive (ibus_drive),
   .db_drive   (db_drive),
   .enabled    (enabled),
   .io_out     (strobes.io_out)
);

`default_nettype wire

// File: sim/mbu_tb.sv
//////////////////////////////////////////////////////////////////////
// Memory bank unit testbench
// Table of steps applied one per clock, checked after the falling edge
// Random rows take their expected values from a byte model of the bank
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mbu_tb;

   import mbu_bus_pkg::*;
   import mbu_ctl_pkg::*;

   // Output checked by a row
   typedef enum logic [1:0] {CHK_NONE, CHK_IBUS, CHK_DB, CHK_AEXT} chk_t;

   // All DUT inputs of one step
   typedef struct packed {
      micro_addr_t raddr;
      micro_addr_t waddr;
      logic        idxen;
      reg_index_t  ir;
      byte_t       ab;
      logic        sysdev;
      logic        io_read;
      logic        io_write;
      byte_t       ibus_in;
      byte_t       db_in;
      logic        rom_sel;
   } stim_t;

   // Expected value is {drive, data} of the checked output
   typedef struct packed {
      stim_t      stim;
      chk_t       chk;
      logic [8:0] exp;
   } row_t;

   logic   clk;
   logic   reset;
   stim_t  drv;
   byte_t  ibus_out;
   byte_t  db_out;
   byte_t  aext;
   logic   ibus_drive;
   logic   db_drive;
   logic   write_ar_mbx;

   // Reference model of the bank and its enable flag
   byte_t  ref_regs [NUM_BANK_REGS];
   logic   ref_en;

   row_t   rows[$];
   string  names[$];
   integer seed;
   int     tests;
   int     errors;

   mbu dut0 (
      .clk          (clk),
      .reset        (reset),
      .raddr        (drv.raddr),
      .waddr        (drv.waddr),
      .idxen        (drv.idxen),
      .ir           (drv.ir),
      .ibus_in      (drv.ibus_in),
      .ab           (drv.ab),
      .db_in        (drv.db_in),
      .sysdev       (drv.sysdev),
      .io_read      (drv.io_read),
      .io_write     (drv.io_write),
      .rom_sel      (drv.rom_sel),
      .ibus_out     (ibus_out),
      .ibus_drive   (ibus_drive),
      .db_out       (db_out),
      .db_drive     (db_drive),
      .aext         (aext),
      .write_ar_mbx (write_ar_mbx)
   );

   // 100 ns clock
   initial clk = 1'b0;
   always #50 clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////////////////////////

   // Byte written by the OUT to window address i
   function automatic byte_t out_byte(int i);
      return 8'h5a + 8'h27 * 8'(i);
   endfunction

   // Strobes straight from the bus rules
   function automatic mbu_strobes_t decode_stim(stim_t s);
      mbu_strobes_t st;
      logic         win;
      win = s.sysdev && (s.ab >= 8'h08) && (s.ab <= 8'h0f);
      st.read_mbp = (s.raddr == ADDR_MBP);
      st.write_mbp = (s.waddr == ADDR_MBP);
      st.write_ar_mbx = (s.waddr[4:2] == 3'b001);
      st.io_in = win && s.io_read;
      st.io_out = win && s.io_write;
      return st;
   endfunction

   // Register picked by the highest priority strobe
   // Idle cycles leave the index at zero
   function automatic reg_index_t model_index(stim_t s);
      mbu_strobes_t st;
      st = decode_stim(s);
      if (st.io_out || st.io_in) begin
         return s.ab[2:0];
      end else if (st.write_ar_mbx) begin
         return {1'b0, s.waddr[1:0]};
      end else if ((st.read_mbp || st.write_mbp) && s.idxen) begin
         return s.ir;
      end
      return '0;
   endfunction

   function automatic logic [8:0] predict(stim_t s, chk_t chk);
      mbu_strobes_t st;
      byte_t        data;
      logic         in_wins;
      st = decode_stim(s);
      // IN owns the data path, IBUS stays quiet then
      in_wins = st.io_in && !st.io_out;
      data = ref_en ? ref_regs[model_index(s)] : {s.rom_sel, 7'b0};
      case (chk)
         CHK_IBUS: return {st.read_mbp && !in_wins, data};
         CHK_DB:   return {in_wins, data};
         CHK_AEXT: return {st.write_ar_mbx, data};
         default:  return '0;
      endcase
   endfunction

   // Writes of one step land on its closing clock edge
   task automatic model_clock(stim_t s);
      mbu_strobes_t st;
      st = decode_stim(s);
      if (st.io_out) begin
         ref_regs[s.ab[2:0]] = s.db_in;
         ref_en = 1'b1;
      end else if (st.write_mbp && !st.io_in) begin
         ref_regs[model_index(s)] = s.ibus_in;
      end
   endtask

   task automatic add_row(string name, stim_t s, chk_t chk, logic [8:0] exp);
      row_t r;
      r.stim = s;
      r.chk = chk;
      r.exp = exp;
      rows.push_back(r);
      names.push_back(name);
      model_clock(s);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Stimulus table
   //////////////////////////////////////////////////////////////////////

   task automatic build_table();
      stim_t       s;
      chk_t        chk;
      byte_t       ar_exp;
      logic [31:0] r;
      logic [63:0] bits;
      // Disabled unit shows the switch in bit 7 for any index
      s = '0;
      s.rom_sel = 1'b1;
      add_row("rst_aext_rom", s, CHK_AEXT, 9'h080);
      s.raddr = ADDR_MBP;
      s.idxen = 1'b1;
      s.ir = 3'd5;
      add_row("rst_ibus_rom", s, CHK_IBUS, 9'h180);
      s.rom_sel = 1'b0;
      add_row("rst_ibus_ram", s, CHK_IBUS, 9'h100);
      s = '0;
      s.waddr = 5'b00110;
      add_row("rst_aext_ram", s, CHK_AEXT, 9'h100);
      // OUT to the whole window, first one still reads disabled
      for (int i = 0; i < 8; i++) begin
         s = '0;
         s.sysdev = 1'b1;
         s.ab = {5'b00001, 3'(i)};
         s.io_write = 1'b1;
         s.db_in = out_byte(i);
         s.rom_sel = 1'b1;
         add_row($sformatf("out_%0d", i), s, (i == 0) ? CHK_DB : CHK_NONE, 9'h080);
      end
      for (int i = 0; i < 8; i++) begin
         s = '0;
         s.sysdev = 1'b1;
         s.ab = {5'b00001, 3'(i)};
         s.io_read = 1'b1;
         add_row($sformatf("in_%0d", i), s, CHK_DB, {1'b1, out_byte(i)});
      end
      // IBUS write through ir, old value on aext during the write
      s = '0;
      s.waddr = ADDR_MBP;
      s.idxen = 1'b1;
      s.ir = 3'd3;
      s.ibus_in = 8'ha5;
      add_row("ibus_wr_ir", s, CHK_AEXT, {1'b0, out_byte(3)});
      s.waddr = '0;
      s.raddr = ADDR_MBP;
      add_row("ibus_rd_ir", s, CHK_IBUS, 9'h1a5);
      // idxen low forces register 0
      s = '0;
      s.waddr = ADDR_MBP;
      s.ir = 3'd6;
      s.ibus_in = 8'h3c;
      add_row("ibus_wr_zero", s, CHK_AEXT, {1'b0, out_byte(0)});
      s.waddr = '0;
      s.raddr = ADDR_MBP;
      add_row("ibus_rd_zero", s, CHK_IBUS, 9'h13c);
      s.idxen = 1'b1;
      add_row("ibus_rd_ir6", s, CHK_IBUS, {1'b1, out_byte(6)});
      // AR writes, waddr low bits select the register
      for (int i = 0; i < 4; i++) begin
         s = '0;
         s.waddr = {3'b001, 2'(i)};
         ar_exp = (i == 0) ? 8'h3c : (i == 3) ? 8'ha5 : out_byte(i);
         add_row($sformatf("ar_write_%0d", i), s, CHK_AEXT, {1'b1, ar_exp});
      end
      // Random mix, biased toward the decoded codes so strobes collide
      for (int i = 0; i < 40; i++) begin
         bits = {$random(seed), $random(seed)};
         r = $random(seed);
         s = bits[41:0];
         if (r[0]) s.raddr = ADDR_MBP;
         case (r[2:1])
            2'd0:    s.waddr = ADDR_MBP;
            2'd1:    s.waddr[4:2] = 3'b001;
            default: ;
         endcase
         if (r[3]) s.ab[7:3] = 5'b00001;
         s.sysdev = r[4] | r[5];
         chk = (r[9:8] == 2'd3) ? CHK_IBUS : chk_t'(r[9:8] + 2'd1);
         add_row($sformatf("rand_%0d", i), s, chk, predict(s, chk));
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Apply and check
   //////////////////////////////////////////////////////////////////////

   task automatic run_table();
      logic [8:0] act;
      for (int i = 0; i < rows.size(); i++) begin
         @(posedge clk);
         drv <= rows[i].stim;
         @(negedge clk);
         case (rows[i].chk)
            CHK_IBUS: act = {ibus_drive, ibus_out};
            CHK_DB:   act = {db_drive, db_out};
            default:  act = {write_ar_mbx, aext};
         endcase
         if (rows[i].chk == CHK_NONE) begin
            $display("applied %s", names[i]);
         end else if (act !== rows[i].exp) begin
            tests++;
            errors++;
            $display("mismatch %s expected %h actual %h", names[i], rows[i].exp, act);
         end else begin
            tests++;
            $display("ok %s", names[i]);
         end
      end
   endtask

   initial begin
      int timeout;
      seed = 45240;
      tests = 0;
      errors = 0;
      ref_en = 1'b0;
      drv = '0;
      reset = 1'b1;
      build_table();
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      // Enable flag must be clear before the first step
      timeout = 0;
      while (dut0.enabled !== 1'b0 && timeout < 10) begin
         @(posedge clk);
         timeout++;
      end
      if (dut0.enabled !== 1'b0) begin
         $display("reset did not clear the enable flag in time");
         $display("** FAIL **");
         $finish;
      end else begin
         run_table();
         $display("tests %0d, errors %0d", tests, errors);
         if (errors == 0) begin
            $display("** PASS **");
         end else begin
            $display("** FAIL **");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: flist.f
source/mbu_bus_pkg.sv
source/mbu_ctl_pkg.sv
source/mbu_decode.sv
source/mbu_control.sv
source/mbu_regfile.sv
source/mbu.sv
sim/mbu_props.sv
sim/mbu_tb.sv
